// ==== design/pw_config.svh ====
`ifndef PW_CONFIG_SVH
`define PW_CONFIG_SVH

// pattern depth, also the byte history depth
`define PW_PATTERN_BYTES   4

// capture FIFO
`define PW_FIFO_DEPTH      16
`define PW_FIFO_AW         4

// field widths
`define PW_DELAY_W         16
`define PW_WIDTH_W         8
`define PW_LEN_W           8
`define PW_TS_W            8

////////////////////
// register map

`define PW_REG_PATTERN0    8'h00
`define PW_REG_PATTERN1    8'h01
`define PW_REG_PATTERN2    8'h02
`define PW_REG_PATTERN3    8'h03
`define PW_REG_MASK0       8'h04
`define PW_REG_MASK1       8'h05
`define PW_REG_MASK2       8'h06
`define PW_REG_MASK3       8'h07
`define PW_REG_PATBYTES    8'h08
`define PW_REG_DELAY_LO    8'h09
`define PW_REG_DELAY_HI    8'h0A
`define PW_REG_WIDTH       8'h0B
`define PW_REG_CAPLEN      8'h0C
`define PW_REG_ARM         8'h0D
`define PW_REG_STATUS      8'h0E
`define PW_REG_FIFO_DATA   8'h10   // peek at head byte
`define PW_REG_FIFO_TIME   8'h11   // pops the head entry
`define PW_REG_FIFO_COUNT  8'h12

`endif

// ==== design/pw_reg_pkg.sv ====
`default_nettype none

package pw_reg_pkg;

   // register bus
   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;

   // status byte, unused bits read as zero
   typedef logic [7:0] status_t;

   localparam int STAT_ARMED      = 0;
   localparam int STAT_CAPTURING  = 1;
   localparam int STAT_DONE       = 2;
   localparam int STAT_FIFO_EMPTY = 3;

endpackage

`default_nettype wire

// ==== design/pw_capture_pkg.sv ====
`default_nettype none
`include "pw_config.svh"

package pw_capture_pkg;

   typedef logic [7:0]                fe_byte_t;     // one PHY byte
   typedef logic [`PW_DELAY_W-1:0]    delay_t;
   typedef logic [`PW_WIDTH_W-1:0]    pwidth_t;
   typedef logic [`PW_LEN_W-1:0]      caplen_t;
   typedef logic [`PW_TS_W-1:0]       tstamp_t;
   typedef logic [`PW_FIFO_AW:0]      fifo_count_t;  // 0 to depth inclusive

   // trigger sequencing
   typedef enum logic [1:0] {
      TRIG_IDLE,
      TRIG_ARMED,
      TRIG_DELAY,
      TRIG_PULSE
   } trig_state_t;

endpackage

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "pw_config.svh"

module reg_file import pw_reg_pkg::*, pw_capture_pkg::*; (
   input  logic        fe_clk,
   input  logic        rst_n_i,
   input  reg_addr_t   reg_addr_i,
   input  reg_data_t   reg_wdata_i,
   input  logic        reg_write_i,
   input  logic        reg_read_i,
   input  logic        armed_i,
   input  logic        capturing_i,
   input  logic        done_i,
   input  logic        fifo_empty_i,
   input  fifo_count_t fifo_count_i,
   input  fe_byte_t    head_data_i,
   input  tstamp_t     head_time_i,
   output reg_data_t   reg_rdata_o,
   output logic        arm_pulse_o,
   output logic        fifo_pop_o,
   output fe_byte_t [`PW_PATTERN_BYTES-1:0] pattern_o,
   output fe_byte_t [`PW_PATTERN_BYTES-1:0] mask_o,
   output logic [2:0]  pat_bytes_o,
   output delay_t      trig_delay_o,
   output pwidth_t     trig_width_o,
   output caplen_t     cap_len_o
);

   status_t   status;
   reg_data_t rd_mux;

   ////////////////////
   // write decode
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pattern_o    <= '0;
         mask_o       <= '1;   // compare all bits by default
         pat_bytes_o  <= 3'd1;
         trig_delay_o <= '0;
         trig_width_o <= pwidth_t'(1);
         cap_len_o    <= caplen_t'(`PW_FIFO_DEPTH);
         arm_pulse_o  <= 1'b0;
      end else begin
         arm_pulse_o <= 1'b0;
         if (reg_write_i) begin
            case (reg_addr_i)
               `PW_REG_PATTERN0, `PW_REG_PATTERN1,
               `PW_REG_PATTERN2, `PW_REG_PATTERN3: pattern_o[reg_addr_i[1:0]] <= reg_wdata_i;
               `PW_REG_MASK0, `PW_REG_MASK1,
               `PW_REG_MASK2, `PW_REG_MASK3:       mask_o[reg_addr_i[1:0]] <= reg_wdata_i;
               `PW_REG_PATBYTES: pat_bytes_o        <= reg_wdata_i[2:0];
               `PW_REG_DELAY_LO: trig_delay_o[7:0]  <= reg_wdata_i;
               `PW_REG_DELAY_HI: trig_delay_o[15:8] <= reg_wdata_i;
               `PW_REG_WIDTH:    trig_width_o       <= reg_wdata_i;
               `PW_REG_CAPLEN:   cap_len_o          <= reg_wdata_i;
               `PW_REG_ARM:      arm_pulse_o        <= reg_wdata_i[0];   // one-cycle strobe
               default: ;
            endcase
         end
      end
   end

   // head entry leaves at the same edge that latches its time
   assign fifo_pop_o = reg_read_i && (reg_addr_i == `PW_REG_FIFO_TIME);

   always_comb begin
      status                  = '0;
      status[STAT_ARMED]      = armed_i;
      status[STAT_CAPTURING]  = capturing_i;
      status[STAT_DONE]       = done_i;
      status[STAT_FIFO_EMPTY] = fifo_empty_i;
   end

   ////////////////////
   // readback
   always_comb begin
      rd_mux = '0;
      case (reg_addr_i)
         `PW_REG_PATTERN0, `PW_REG_PATTERN1,
         `PW_REG_PATTERN2, `PW_REG_PATTERN3: rd_mux = pattern_o[reg_addr_i[1:0]];
         `PW_REG_MASK0, `PW_REG_MASK1,
         `PW_REG_MASK2, `PW_REG_MASK3:       rd_mux = mask_o[reg_addr_i[1:0]];
         `PW_REG_PATBYTES:   rd_mux = {5'd0, pat_bytes_o};
         `PW_REG_DELAY_LO:   rd_mux = trig_delay_o[7:0];
         `PW_REG_DELAY_HI:   rd_mux = trig_delay_o[15:8];
         `PW_REG_WIDTH:      rd_mux = trig_width_o;
         `PW_REG_CAPLEN:     rd_mux = cap_len_o;
         `PW_REG_ARM:        rd_mux = {7'd0, armed_i};
         `PW_REG_STATUS:     rd_mux = status;
         `PW_REG_FIFO_DATA:  rd_mux = fifo_empty_i ? '0 : head_data_i;
         `PW_REG_FIFO_TIME:  rd_mux = fifo_empty_i ? '0 : head_time_i;
         `PW_REG_FIFO_COUNT: rd_mux = reg_data_t'(fifo_count_i);
         default: ;
      endcase
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i)
         reg_rdata_o <= '0;
      else if (reg_read_i)
         reg_rdata_o <= rd_mux;   // held until the next read
   end

endmodule

`default_nettype wire

// ==== design/pattern_matcher.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "pw_config.svh"

module pattern_matcher import pw_capture_pkg::*; (
   input  logic       fe_clk,
   input  logic       rst_n_i,
   input  fe_byte_t   fe_data_i,
   input  logic       fe_rxvalid_i,
   input  logic       armed_i,
   input  fe_byte_t [`PW_PATTERN_BYTES-1:0] pattern_i,
   input  fe_byte_t [`PW_PATTERN_BYTES-1:0] mask_i,
   input  logic [2:0] pat_bytes_i,
   output logic       match_o
);

   fe_byte_t [`PW_PATTERN_BYTES-2:0] history;   // older bytes, [0] most recent
   fe_byte_t [`PW_PATTERN_BYTES-1:0] window;    // incoming byte at [0]
   logic [2:0] active;
   logic       hit;

   assign window = {history, fe_data_i};

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i)
         history <= '0;
      else if (fe_rxvalid_i)
         history <= window[`PW_PATTERN_BYTES-2:0];
   end

   // 0 behaves as 1, anything above the depth as the full depth
   always_comb begin
      if (pat_bytes_i == 3'd0)
         active = 3'd1;
      else if (pat_bytes_i > 3'(`PW_PATTERN_BYTES))
         active = 3'(`PW_PATTERN_BYTES);
      else
         active = pat_bytes_i;
   end

   // mask bit set means the bit must match
   always_comb begin
      hit = 1'b1;
      for (int i = 0; i < `PW_PATTERN_BYTES; i++) begin
         if ((3'(i) < active) && (((window[i] ^ pattern_i[i]) & mask_i[i]) != 8'h00))
            hit = 1'b0;
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i)
         match_o <= 1'b0;
      else
         match_o <= armed_i && fe_rxvalid_i && hit;   // single-cycle strobe
   end

endmodule

`default_nettype wire

// ==== design/trigger_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module trigger_fsm import pw_capture_pkg::*; (
   input  logic    fe_clk,
   input  logic    rst_n_i,
   input  logic    arm_pulse_i,
   input  logic    match_i,
   input  logic    timer_done_i,
   input  delay_t  trig_delay_i,
   input  pwidth_t trig_width_i,
   output logic    armed_o,
   output logic    timer_load_o,
   output delay_t  timer_value_o,
   output logic    cw_trig_o
);

   trig_state_t state;
   trig_state_t state_nxt;
   delay_t      width_eff;

   // zero width still gives a pulse
   assign width_eff = (trig_width_i == '0) ? delay_t'(1) : delay_t'(trig_width_i);

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i)
         state <= TRIG_IDLE;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt     = state;
      timer_load_o  = 1'b0;
      timer_value_o = trig_delay_i;
      case (state)
         TRIG_IDLE: begin
            if (arm_pulse_i)
               state_nxt = TRIG_ARMED;
         end
         TRIG_ARMED: begin
            if (match_i) begin
               state_nxt    = TRIG_DELAY;
               timer_load_o = 1'b1;   // start delay count
            end
         end
         TRIG_DELAY: begin
            if (timer_done_i) begin
               state_nxt     = TRIG_PULSE;
               timer_load_o  = 1'b1;
               timer_value_o = width_eff;
            end
         end
         TRIG_PULSE: begin
            if (timer_done_i)
               state_nxt = TRIG_IDLE;
         end
         default: state_nxt = TRIG_IDLE;
      endcase
   end

   assign armed_o   = (state == TRIG_ARMED);
   assign cw_trig_o = (state == TRIG_PULSE);

endmodule

`default_nettype wire

// ==== design/trigger_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

module trigger_timer import pw_capture_pkg::*; (
   input  logic   fe_clk,
   input  logic   rst_n_i,
   input  logic   load_i,
   input  delay_t value_i,
   output logic   done_o
);

   delay_t count;
   logic   busy;

   ////////////////////
   // load wins over expiry so back-to-back phases chain
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count <= '0;
         busy  <= 1'b0;
      end else if (load_i) begin
         count <= value_i;
         busy  <= 1'b1;
      end else if (busy) begin
         if (count == '0)
            busy <= 1'b0;
         else
            count <= count - 1'b1;
      end
   end

   // value+1 cycles after the load cycle
   assign done_o = busy && (count == '0);

endmodule

`default_nettype wire

// ==== design/capture_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "pw_config.svh"

module capture_fifo import pw_capture_pkg::*; (
   input  logic        fe_clk,
   input  logic        rst_n_i,
   input  logic        arm_pulse_i,
   input  logic        match_i,
   input  fe_byte_t    fe_data_i,
   input  logic        fe_rxvalid_i,
   input  caplen_t     cap_len_i,
   input  logic        pop_i,
   output logic        capturing_o,
   output logic        done_o,
   output logic        fifo_empty_o,
   output fifo_count_t fifo_count_o,
   output fe_byte_t    head_data_o,
   output tstamp_t     head_time_o
);

   fe_byte_t data_mem [`PW_FIFO_DEPTH];
   tstamp_t  time_mem [`PW_FIFO_DEPTH];
   logic [`PW_FIFO_AW-1:0] wr_ptr;
   logic [`PW_FIFO_AW-1:0] rd_ptr;
   fifo_count_t count;
   caplen_t     cap_cnt;    // bytes stored since the match
   tstamp_t     tstamp;
   tstamp_t     wr_time;
   logic        wr_en;
   logic        rd_en;
   logic        last;

   // byte arriving with the match strobe is the first one, at time 0
   assign wr_en   = fe_rxvalid_i && (capturing_o || (match_i && cap_len_i != '0));
   assign wr_time = match_i ? '0 : tstamp;
   assign rd_en   = pop_i && (count != '0);   // empty read pops nothing
   assign last    = (caplen_t'(cap_cnt + 1'b1) >= cap_len_i) ||
                    (cap_cnt == caplen_t'(`PW_FIFO_DEPTH - 1));

   ////////////////////
   // capture control and timestamp
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         capturing_o <= 1'b0;
         done_o      <= 1'b0;
         cap_cnt     <= '0;
         tstamp      <= '0;
      end else if (arm_pulse_i) begin
         capturing_o <= 1'b0;
         done_o      <= 1'b0;
         cap_cnt     <= '0;
      end else begin
         if (match_i)
            tstamp <= tstamp_t'(1);
         else if (tstamp != '1)
            tstamp <= tstamp + 1'b1;   // saturates
         if (wr_en) begin
            cap_cnt     <= cap_cnt + 1'b1;
            capturing_o <= !last;
            done_o      <= last;
         end else if (match_i) begin
            capturing_o <= (cap_len_i != '0);
            done_o      <= (cap_len_i == '0);
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (wr_en) begin
         data_mem[wr_ptr] <= fe_data_i;
         time_mem[wr_ptr] <= wr_time;
      end
   end

   // pointers, flushed on arm
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (arm_pulse_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   assign fifo_empty_o = (count == '0);
   assign fifo_count_o = count;
   assign head_data_o  = data_mem[rd_ptr];
   assign head_time_o  = time_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== design/phywhisperer_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "pw_config.svh"

module phywhisperer_top import pw_reg_pkg::*, pw_capture_pkg::*; (
   input  logic      fe_clk,
   input  logic      rst_n_i,
   input  reg_addr_t reg_addr_i,
   input  reg_data_t reg_wdata_i,
   input  logic      reg_write_i,
   input  logic      reg_read_i,
   input  fe_byte_t  fe_data_i,
   input  logic      fe_rxvalid_i,
   output reg_data_t reg_rdata_o,
   output logic      cw_trig_o
);

   logic        arm_pulse;
   logic        fifo_pop;
   logic        armed;
   logic        match;
   logic        capturing;
   logic        done;
   logic        fifo_empty;
   fifo_count_t fifo_count;
   fe_byte_t    head_data;
   tstamp_t     head_time;
   fe_byte_t [`PW_PATTERN_BYTES-1:0] pattern;
   fe_byte_t [`PW_PATTERN_BYTES-1:0] mask;
   logic [2:0]  pat_bytes;
   delay_t      trig_delay;
   pwidth_t     trig_width;
   caplen_t     cap_len;
   logic        timer_load;
   delay_t      timer_value;
   logic        timer_done;

   ////////////////////
   // register side
   reg_file u_reg_file (
      .fe_clk       (fe_clk),
      .rst_n_i      (rst_n_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_write_i  (reg_write_i),
      .reg_read_i   (reg_read_i),
      .armed_i      (armed),
      .capturing_i  (capturing),
      .done_i       (done),
      .fifo_empty_i (fifo_empty),
      .fifo_count_i (fifo_count),
      .head_data_i  (head_data),
      .head_time_i  (head_time),
      .reg_rdata_o  (reg_rdata_o),
      .arm_pulse_o  (arm_pulse),
      .fifo_pop_o   (fifo_pop),
      .pattern_o    (pattern),
      .mask_o       (mask),
      .pat_bytes_o  (pat_bytes),
      .trig_delay_o (trig_delay),
      .trig_width_o (trig_width),
      .cap_len_o    (cap_len)
   );

   ////////////////////
   // sniffer path
   pattern_matcher u_pattern_matcher (
      .fe_clk       (fe_clk),
      .rst_n_i      (rst_n_i),
      .fe_data_i    (fe_data_i),
      .fe_rxvalid_i (fe_rxvalid_i),
      .armed_i      (armed),
      .pattern_i    (pattern),
      .mask_i       (mask),
      .pat_bytes_i  (pat_bytes),
      .match_o      (match)
   );

   trigger_fsm u_trigger_fsm (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .arm_pulse_i   (arm_pulse),
      .match_i       (match),
      .timer_done_i  (timer_done),
      .trig_delay_i  (trig_delay),
      .trig_width_i  (trig_width),
      .armed_o       (armed),
      .timer_load_o  (timer_load),
      .timer_value_o (timer_value),
      .cw_trig_o     (cw_trig_o)
   );

   trigger_timer u_trigger_timer (
      .fe_clk  (fe_clk),
      .rst_n_i (rst_n_i),
      .load_i  (timer_load),
      .value_i (timer_value),
      .done_o  (timer_done)
   );

   capture_fifo u_capture_fifo (
      .fe_clk       (fe_clk),
      .rst_n_i      (rst_n_i),
      .arm_pulse_i  (arm_pulse),
      .match_i      (match),
      .fe_data_i    (fe_data_i),
      .fe_rxvalid_i (fe_rxvalid_i),
      .cap_len_i    (cap_len),
      .pop_i        (fifo_pop),
      .capturing_o  (capturing),
      .done_o       (done),
      .fifo_empty_o (fifo_empty),
      .fifo_count_o (fifo_count),
      .head_data_o  (head_data),
      .head_time_o  (head_time)
   );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS    = 4.0,
   parameter int  RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   // reset released on a rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== bench/pw_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "pw_config.svh"

module pw_asserts import pw_capture_pkg::*; (
   input wire logic        clk_i,
   input wire logic        rst_n_i,
   input wire trig_state_t state_i,
   input wire logic        cw_trig_i,
   input wire fifo_count_t fifo_count_i,
   input wire logic        capturing_i,
   input wire logic        done_i
);

   // pulse phase only, and only reached through the delay phase
   trig_only_in_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cw_trig_i |-> (state_i == TRIG_PULSE) &&
                    (($past(state_i) == TRIG_DELAY) || ($past(state_i) == TRIG_PULSE)))
      else $error("cw_trig_o high outside a pulse that follows the delay phase");

   fifo_count_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fifo_count_i <= fifo_count_t'(`PW_FIFO_DEPTH))
      else $error("FIFO count above depth");

   // a running capture has not finished and still has room
   capture_xor_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      capturing_i |-> !done_i && (fifo_count_i < fifo_count_t'(`PW_FIFO_DEPTH)))
      else $error("capturing while done is set or the FIFO is full");

endmodule

////////////////////
// each instance ties off the side it does not watch
bind trigger_fsm pw_asserts u_fsm_asserts (
   .clk_i        (fe_clk),
   .rst_n_i      (rst_n_i),
   .state_i      (state),
   .cw_trig_i    (cw_trig_o),
   .fifo_count_i ('0),
   .capturing_i  (1'b0),
   .done_i       (1'b0)
);

bind capture_fifo pw_asserts u_fifo_asserts (
   .clk_i        (fe_clk),
   .rst_n_i      (rst_n_i),
   .state_i      (pw_capture_pkg::TRIG_IDLE),
   .cw_trig_i    (1'b0),
   .fifo_count_i (fifo_count_o),
   .capturing_i  (capturing_o),
   .done_i       (done_o)
);

`default_nettype wire

// ==== bench/pw_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "pw_config.svh"

module pw_tb import pw_reg_pkg::*, pw_capture_pkg::*; ();

   logic      clk;
   logic      rst_n;
   reg_addr_t reg_addr;
   reg_data_t reg_wdata;
   reg_data_t reg_rdata;
   logic      reg_write;
   logic      reg_read;
   fe_byte_t  fe_data;
   logic      fe_rxvalid;
   logic      cw_trig;

   int seed = 32'he1fa;
   int cyc = 0;            // rising edge index
   int errors = 0;
   int timeouts = 0;
   int checks = 0;

   // monitor record of sampled bytes and trigger pulses
   int       st_cyc[$];
   fe_byte_t st_byte[$];
   int       rise_q[$];
   int       width_q[$];
   logic     cw_prev = 1'b0;
   int       hi_cnt = 0;

   // pending compares
   string cmp_name[$];
   int    cmp_exp[$];
   int    cmp_act[$];

   // configuration mirror and expected FIFO entries
   fe_byte_t cfg_pat[4];
   fe_byte_t cfg_mask[4];
   int cfg_nbytes;
   int cfg_delay;
   int cfg_width;
   int cfg_caplen;
   int exp_data[$];
   int exp_time[$];
   fe_byte_t burst_q[$];

   tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(16)) u_clock_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   phywhisperer_top i_dut (
      .fe_clk       (clk),
      .rst_n_i      (rst_n),
      .reg_addr_i   (reg_addr),
      .reg_wdata_i  (reg_wdata),
      .reg_write_i  (reg_write),
      .reg_read_i   (reg_read),
      .fe_data_i    (fe_data),
      .fe_rxvalid_i (fe_rxvalid),
      .reg_rdata_o  (reg_rdata),
      .cw_trig_o    (cw_trig)
   );

   ////////////////////
   // monitor
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (rst_n) begin
         if (fe_rxvalid) begin
            st_cyc.push_back(cyc);
            st_byte.push_back(fe_data);
         end
         if (cw_trig) begin
            if (!cw_prev)
               rise_q.push_back(cyc - 1);   // edge after which it went high
            hi_cnt = hi_cnt + 1;
         end else if (cw_prev) begin
            width_q.push_back(hi_cnt);
            hi_cnt = 0;
         end
         cw_prev = cw_trig;
      end
   end

   task automatic check(input string name, input int exp_v, input int act_v);
      checks++;
      if (exp_v != act_v) begin
         errors++;
         $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
      end
   endtask

   // compare process
   always @(posedge clk) begin
      while (cmp_name.size() > 0)
         check(cmp_name.pop_front(), cmp_exp.pop_front(), cmp_act.pop_front());
   end

   task automatic expect_value(input string name, input int exp_v, input int act_v);
      cmp_name.push_back(name);
      cmp_exp.push_back(exp_v);
      cmp_act.push_back(act_v);
   endtask

   ////////////////////
   // reference model
   function automatic int ref_match_edge(input int from_edge);
      int n;
      bit hit;
      fe_byte_t b;
      n = (cfg_nbytes == 0) ? 1 : ((cfg_nbytes > 4) ? 4 : cfg_nbytes);
      for (int i = 0; i < st_cyc.size(); i++) begin
         if (st_cyc[i] >= from_edge) begin
            hit = 1'b1;
            for (int k = 0; k < n; k++) begin
               b = (i - k >= 0) ? st_byte[i - k] : 8'h00;   // history is zero after reset
               if (((b ^ cfg_pat[k]) & cfg_mask[k]) != 8'h00)
                  hit = 1'b0;
            end
            if (hit)
               return st_cyc[i];
         end
      end
      return -1;
   endfunction

   function automatic void build_expected(input int m);
      int n;
      int t;
      n = (cfg_caplen > 16) ? 16 : cfg_caplen;
      exp_data.delete();
      exp_time.delete();
      for (int i = 0; i < st_cyc.size(); i++) begin
         if (st_cyc[i] >= m + 1 && exp_data.size() < n) begin
            t = st_cyc[i] - (m + 1);
            exp_data.push_back(st_byte[i]);
            exp_time.push_back((t > 255) ? 255 : t);   // timestamp saturates
         end
      end
   endfunction

   ////////////////////
   // bus and PHY drivers
   task automatic write_reg(input reg_addr_t a, input reg_data_t d);
      @(posedge clk);
      reg_addr  <= a;
      reg_wdata <= d;
      reg_write <= 1'b1;
      @(posedge clk);
      reg_write <= 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t a, output reg_data_t d);
      @(posedge clk);
      reg_addr <= a;
      reg_read <= 1'b1;
      @(posedge clk);
      reg_read <= 1'b0;
      @(negedge clk);
      d = reg_rdata;
   endtask

   task automatic send_byte(input fe_byte_t b);
      while (($random(seed) & 3) == 0) begin
         @(posedge clk);
         fe_rxvalid <= 1'b0;   // idle gap
      end
      @(posedge clk);
      fe_data    <= b;
      fe_rxvalid <= 1'b1;
   endtask

   task automatic send_filler(input int n);
      for (int i = 0; i < n; i++)
         send_byte(fe_byte_t'($random(seed)));
      @(posedge clk);
      fe_rxvalid <= 1'b0;
   endtask

   task automatic configure(input int nbytes, input int delay, input int width,
                            input int caplen);
      for (int k = 0; k < 4; k++) begin
         write_reg(reg_addr_t'(`PW_REG_PATTERN0 + k), cfg_pat[k]);
         write_reg(reg_addr_t'(`PW_REG_MASK0 + k), cfg_mask[k]);
      end
      write_reg(`PW_REG_PATBYTES, reg_data_t'(nbytes));
      write_reg(`PW_REG_DELAY_LO, reg_data_t'(delay));
      write_reg(`PW_REG_DELAY_HI, reg_data_t'(delay >> 8));
      write_reg(`PW_REG_WIDTH, reg_data_t'(width));
      write_reg(`PW_REG_CAPLEN, reg_data_t'(caplen));
      cfg_nbytes = nbytes;
      cfg_delay  = delay;
      cfg_width  = width;
      cfg_caplen = caplen;
   endtask

   // arm, send burst_q in traffic, check trigger and FIFO contents
   task automatic run_capture(input bit drain_all);
      int arm_edge;
      int m;
      int n_rise;
      int n_width;
      int guard;
      reg_data_t d;
      n_rise  = rise_q.size();
      n_width = width_q.size();
      write_reg(`PW_REG_ARM, 8'h01);
      arm_edge = cyc;
      read_reg(`PW_REG_STATUS, d);
      expect_value("status after arm", 8'h09, d);   // armed, fifo empty
      send_filler(6);
      foreach (burst_q[i])
         send_byte(burst_q[i]);
      send_filler(24);
      m = ref_match_edge(arm_edge + 2);
      if (m < 0) begin
         errors++;
         $display("reference model found no match in the sent traffic");
         return;
      end
      guard = 0;
      while (width_q.size() <= n_width && guard < 2000) begin
         @(posedge clk);
         guard++;
      end
      if (guard >= 2000) begin
         timeouts++;
         $display("timeout waiting for the trigger pulse to end");
         return;
      end
      expect_value("cw_trig_o rise count", n_rise + 1, rise_q.size());
      expect_value("cw_trig_o rise edge", m + cfg_delay + 2, rise_q[n_rise]);
      expect_value("cw_trig_o width", ((cfg_width == 0) ? 1 : cfg_width) + 1,
                   width_q[n_width]);
      guard = 0;
      d = '0;
      while (d[2] == 1'b0 && guard < 200) begin
         read_reg(`PW_REG_STATUS, d);
         guard++;
      end
      if (guard >= 200) begin
         timeouts++;
         $display("timeout waiting for the capture to finish");
         return;
      end
      build_expected(m);
      expect_value("status after capture", 8'h04, d);
      read_reg(`PW_REG_FIFO_COUNT, d);
      expect_value("fifo_count", exp_data.size(), d);
      foreach (exp_data[i]) begin
         if (drain_all || i < 3) begin
            read_reg(`PW_REG_FIFO_DATA, d);
            expect_value("fifo_data", exp_data[i], d);
            read_reg(`PW_REG_FIFO_TIME, d);
            expect_value("fifo_time", exp_time[i], d);
         end
      end
      if (drain_all) begin
         read_reg(`PW_REG_FIFO_DATA, d);
         expect_value("fifo_data when empty", 0, d);
         read_reg(`PW_REG_FIFO_TIME, d);
         expect_value("fifo_time when empty", 0, d);
         read_reg(`PW_REG_FIFO_COUNT, d);
         expect_value("fifo_count when empty", 0, d);
         read_reg(`PW_REG_STATUS, d);
         expect_value("status when drained", 8'h0C, d);
      end
      expect_value("cw_trig_o single pulse", n_rise + 1, rise_q.size());
   endtask

   ////////////////////
   // stimulus
   initial begin
      int guard;
      reg_data_t d;
      fe_byte_t x;
      reg_addr   = '0;
      reg_wdata  = '0;
      reg_write  = 1'b0;
      reg_read   = 1'b0;
      fe_data    = '0;
      fe_rxvalid = 1'b0;

      guard = 0;
      while (rst_n !== 1'b1 && guard < 100) begin
         @(posedge clk);
         guard++;
      end
      if (guard >= 100) begin
         timeouts++;
         $display("reset was never released");
      end

      // 1: idle state, no trigger while unarmed
      cfg_pat  = '{8'hA5, 8'h3C, 8'h5A, 8'hC3};
      cfg_mask = '{8'hF0, 8'hFF, 8'h0F, 8'hFF};
      configure(4, 5, 3, 5);
      read_reg(`PW_REG_STATUS, d);
      expect_value("status after reset", 8'h08, d);
      send_filler(30);
      expect_value("cw_trig_o rises unarmed", 0, rise_q.size());

      // 2: pattern while not armed, then armed with don't-care bits flipped
      for (int k = 3; k >= 0; k--)
         send_byte(cfg_pat[k]);
      send_filler(10);
      expect_value("cw_trig_o rises unarmed pattern", 0, rise_q.size());
      burst_q.delete();
      for (int k = 3; k >= 0; k--) begin
         x = fe_byte_t'($random(seed));
         burst_q.push_back(cfg_pat[k] ^ (x & ~cfg_mask[k]));
      end
      run_capture(1'b1);

      // 3: two newest bytes only, FIFO fills to depth
      cfg_mask = '{8'hFF, 8'hFF, 8'hFF, 8'hFF};
      configure(2, 12, 0, 20);
      burst_q.delete();
      burst_q.push_back(~cfg_pat[3]);
      burst_q.push_back(~cfg_pat[2]);
      burst_q.push_back(cfg_pat[1]);
      burst_q.push_back(cfg_pat[0]);
      run_capture(1'b0);

      // 5: re-arm flushes the partly read FIFO, second match
      configure(4, 0, 7, 8);
      burst_q.delete();
      for (int k = 3; k >= 0; k--)
         burst_q.push_back(cfg_pat[k]);
      run_capture(1'b1);

      guard = 0;
      while (cmp_name.size() > 0 && guard < 10) begin
         @(posedge clk);
         guard++;
      end
      if (guard >= 10) begin
         timeouts++;
         $display("compare queue did not drain");
      end
      @(posedge clk);
      $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/pw_reg_pkg.sv
design/pw_capture_pkg.sv
design/reg_file.sv
design/pattern_matcher.sv
design/trigger_fsm.sv
design/trigger_timer.sv
design/capture_fifo.sv
design/phywhisperer_top.sv
bench/tb_clock_gen.sv
bench/pw_asserts.sv
bench/pw_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module pw_tb -f sources.f -o Vpw_tb
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

out=$(./obj_dir/Vpw_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
   exit 0
fi
exit 1
